//--- design/hps_bus_pkg.sv
/*
 * Bus-level types for the host I/O bridge.
 * Holds the bus word, the word counter width and the structs that carry
 * the host bus, the decoded frame state and the decoder replies between
 * the RTL blocks. Referenced by scoped name only.
 */

package hps_bus_pkg;

	// one 16-bit word on the host bus
	typedef logic [15:0] io_word_t;

	// word counter saturates at all ones
	localparam int WORD_CNT_W = 9;
	typedef logic [WORD_CNT_W-1:0] word_cnt_t;

	// core-side payload types
	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;

	// [10] toggle, [9] pressed, [8] extended, [7:0] scan code
	typedef logic [10:0] key_event_t;

	// raw host bus as seen at the top level
	typedef struct packed {
		logic     strobe;
		logic     enable;
		io_word_t din;
	} host_bus_t;

	// frame state handed to the decoders
	typedef struct packed {
		io_word_t  cmd;
		word_cnt_t word_cnt;
		logic      cmd_stb;
		logic      data_stb;
		io_word_t  din;
		logic      frame_end;
		io_word_t  last_cmd;
	} frame_t;

	// read reply of one decoder
	typedef struct packed {
		logic     valid;
		io_word_t data;
	} reply_t;

endpackage

//--- design/hps_cmd_pkg.sv
/*
 * Command codes and keyboard constants of the host protocol.
 * The command words select the decoder that owns a frame; the scan code
 * constants drive the key event assembly.
 */

package hps_cmd_pkg;

	////////////////////
	// command words
	////////////////////

	localparam hps_bus_pkg::io_word_t CMD_CFG        = 16'h0001;
	localparam hps_bus_pkg::io_word_t CMD_JOY0       = 16'h0002;
	localparam hps_bus_pkg::io_word_t CMD_JOY1       = 16'h0003;
	localparam hps_bus_pkg::io_word_t CMD_KBD        = 16'h0005;
	localparam hps_bus_pkg::io_word_t CMD_STATUS     = 16'h001E;
	localparam hps_bus_pkg::io_word_t CMD_LEDS       = 16'h001F;
	localparam hps_bus_pkg::io_word_t CMD_STATUS_SET = 16'h0029;
	localparam hps_bus_pkg::io_word_t CMD_MENUMASK   = 16'h002E;

	// upper nibble of the status-set reply byte
	localparam logic [3:0] STATUS_SET_TAG = 4'hA;

	////////////////////
	// keyboard codes
	////////////////////

	localparam logic [7:0] KEY_BREAK   = 8'hF0;
	localparam logic [7:0] KEY_EXT     = 8'hE0;
	localparam logic [7:0] SKIP_PREFIX = 8'hFF;

	// multi-byte sequences, oldest byte highest
	localparam logic [31:0] PRNSCR_MAKE  = 32'hE012E07C;
	localparam logic [31:0] PRNSCR_BREAK = 32'h7CE0F012;
	localparam logic [31:0] PAUSE_MAKE   = 32'hF014F077;

	// replacement for bits 9:0 of the event
	localparam logic [9:0] PRNSCR_EV_MAKE  = 10'h37C;
	localparam logic [9:0] PRNSCR_EV_BREAK = 10'h17C;
	localparam logic [9:0] PAUSE_EV        = 10'h377;

endpackage

//--- design/cmd_frame.sv
/*
 * Frame tracker for the host command channel.
 * Latches the command word on the first strobe of an enable frame and
 * counts the words after it. Splits strobes into command and data strobes
 * and flags the end of each frame for the decoders.
 */

`timescale 1ns/1ps

module cmd_frame (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  hps_bus_pkg::host_bus_t bus,
	output hps_bus_pkg::frame_t    frame
);

	hps_bus_pkg::io_word_t  cmd_q;
	hps_bus_pkg::word_cnt_t cnt_q;
	logic                   open_q;
	logic                   strobe;

	// strobes outside an enable frame are ignored
	assign strobe = bus.enable & bus.strobe;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd_q  <= '0;
			cnt_q  <= '0;
			open_q <= 1'b0;
		end else begin
			open_q <= bus.enable;
			if (!bus.enable) begin
				cmd_q <= '0;
				cnt_q <= '0;
			end else if (strobe) begin
				if (cnt_q == '0)
					cmd_q <= bus.din;
				if (~&cnt_q)
					cnt_q <= cnt_q + hps_bus_pkg::word_cnt_t'(1);
			end
		end
	end

	always_comb begin
		frame.cmd_stb   = strobe && (cnt_q == '0);
		frame.data_stb  = strobe && (cnt_q != '0);
		// command is visible to the decoders on its own strobe
		frame.cmd       = frame.cmd_stb ? bus.din : cmd_q;
		frame.word_cnt  = cnt_q;
		frame.din       = bus.din;
		frame.frame_end = open_q && !bus.enable;
		frame.last_cmd  = cmd_q;
	end

	// counter saturates, never wraps back to zero mid-frame
	a_cnt_no_wrap: assert property (@(posedge clk_sys) disable iff (reset)
		(bus.enable && cnt_q != '0) |=> (cnt_q != '0));

endmodule

//--- design/status_regs.sv
/*
 * Configuration, joystick and status registers of the bridge.
 * Data words of the owning commands write the core-facing registers.
 * A rising status_set from the core snapshots status_in and bumps a
 * 4-bit counter that the host polls through the status-set command.
 * Drives the read reply for every command it owns.
 */

`timescale 1ns/1ps

module status_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  hps_bus_pkg::frame_t    frame,
	input  logic                   status_set,
	input  hps_bus_pkg::status_t   status_in,
	input  hps_bus_pkg::io_word_t  status_menumask,
	output hps_bus_pkg::io_word_t  cfg_word,
	output hps_bus_pkg::joy_t      joystick_0,
	output hps_bus_pkg::joy_t      joystick_1,
	output hps_bus_pkg::status_t   status,
	output hps_bus_pkg::reply_t    reply
);

	logic                 set_d;
	logic                 set_rise;
	logic [3:0]           set_cnt;
	hps_bus_pkg::status_t status_req;
	logic                 in_quad;
	logic [1:0]           quad;

	// word 1 loads the low half, any later word the high half
	function automatic hps_bus_pkg::joy_t joy_write(
		input hps_bus_pkg::joy_t      cur,
		input hps_bus_pkg::word_cnt_t cnt,
		input hps_bus_pkg::io_word_t  din
	);
		hps_bus_pkg::joy_t nxt;
		nxt = cur;
		if (cnt == hps_bus_pkg::word_cnt_t'(1))
			nxt[15:0] = din;
		else
			nxt[31:16] = din;
		return nxt;
	endfunction

	// words 1 to 4 map to the four 16-bit quarters
	assign in_quad  = (frame.word_cnt != '0) &&
		(frame.word_cnt <= hps_bus_pkg::word_cnt_t'(4));
	assign quad     = frame.word_cnt[1:0] - 2'd1;
	assign set_rise = status_set && !set_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg_word   <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			set_d      <= 1'b0;
			set_cnt    <= '0;
		end else begin
			set_d <= status_set;
			if (set_rise)
				set_cnt <= set_cnt + 4'd1;
			if (frame.data_stb) begin
				case (frame.cmd)
					hps_cmd_pkg::CMD_CFG:  cfg_word <= frame.din;
					hps_cmd_pkg::CMD_JOY0:
						joystick_0 <= joy_write(joystick_0, frame.word_cnt, frame.din);
					hps_cmd_pkg::CMD_JOY1:
						joystick_1 <= joy_write(joystick_1, frame.word_cnt, frame.din);
					hps_cmd_pkg::CMD_STATUS:
						if (in_quad)
							status[{quad, 4'b0000} +: 16] <= frame.din;
					default: ;
				endcase
			end
		end
	end

	// snapshot of the core's request
	always_ff @(posedge clk_sys) begin
		if (set_rise)
			status_req <= status_in;
	end

	////////////////////
	// read reply
	////////////////////

	always_comb begin
		reply.valid = 1'b0;
		reply.data  = '0;
		if (frame.cmd_stb || frame.data_stb) begin
			case (frame.cmd)
				hps_cmd_pkg::CMD_CFG,
				hps_cmd_pkg::CMD_JOY0,
				hps_cmd_pkg::CMD_JOY1,
				hps_cmd_pkg::CMD_STATUS:
					reply.valid = 1'b1;
				hps_cmd_pkg::CMD_STATUS_SET: begin
					reply.valid = 1'b1;
					if (frame.cmd_stb)
						reply.data = {8'h00, hps_cmd_pkg::STATUS_SET_TAG, set_cnt};
					else if (in_quad)
						reply.data = status_req[{quad, 4'b0000} +: 16];
				end
				hps_cmd_pkg::CMD_MENUMASK: begin
					reply.valid = 1'b1;
					if (frame.word_cnt == hps_bus_pkg::word_cnt_t'(1))
						reply.data = status_menumask;
				end
				default: ;
			endcase
		end
	end

endmodule

//--- design/key_events.sv
/*
 * Keyboard event decoder.
 * Collects the scan bytes of a keyboard frame in a 32-bit shift register
 * and turns them into one key event when the frame closes. Frames that
 * carry a 0xFF prefix byte are dropped. Also answers the LED status read.
 */

`timescale 1ns/1ps

module key_events (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  hps_bus_pkg::frame_t     frame,
	input  logic [2:0]              kbd_led_status,
	input  logic [2:0]              kbd_led_use,
	output hps_bus_pkg::key_event_t ps2_key,
	output hps_bus_pkg::reply_t     reply
);

	logic [31:0]             raw_q;
	logic                    skip_q;
	logic                    kbd_data;
	logic                    skip_word;
	logic                    pressed;
	logic                    extended;
	hps_bus_pkg::key_event_t key_next;
	hps_bus_pkg::io_word_t   led_word;

	assign kbd_data  = frame.data_stb && (frame.cmd == hps_cmd_pkg::CMD_KBD);
	assign skip_word = frame.din[15:8] == hps_cmd_pkg::SKIP_PREFIX;

	always_comb begin
		pressed  = raw_q[15:8] != hps_cmd_pkg::KEY_BREAK;
		// on release the E0 sits one byte further back, before the F0
		extended = pressed ? (raw_q[15:8] == hps_cmd_pkg::KEY_EXT) :
			(raw_q[23:16] == hps_cmd_pkg::KEY_EXT);
		key_next = {~ps2_key[10], pressed, extended, raw_q[7:0]};
		case (raw_q)
			hps_cmd_pkg::PRNSCR_MAKE:  key_next[9:0] = hps_cmd_pkg::PRNSCR_EV_MAKE;
			hps_cmd_pkg::PRNSCR_BREAK: key_next[9:0] = hps_cmd_pkg::PRNSCR_EV_BREAK;
			hps_cmd_pkg::PAUSE_MAKE:   key_next[9:0] = hps_cmd_pkg::PAUSE_EV;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			skip_q  <= 1'b0;
			ps2_key <= '0;
		end else if (frame.frame_end) begin
			skip_q <= 1'b0;
			if (frame.last_cmd == hps_cmd_pkg::CMD_KBD && !skip_q)
				ps2_key <= key_next;
		end else if (kbd_data && skip_word) begin
			skip_q <= 1'b1;
		end
	end

	// scan byte history, newest byte lowest
	always_ff @(posedge clk_sys) begin
		if (frame.cmd_stb && frame.cmd == hps_cmd_pkg::CMD_KBD)
			raw_q <= '0;
		else if (kbd_data && !skip_word && !skip_q)
			raw_q <= {raw_q[23:0], frame.din[7:0]};
	end

	////////////////////
	// LED status reply
	////////////////////

	// bit 8 is the wire-level write enable, absent here
	assign led_word = {8'h00, 2'b01,
		kbd_led_status[2], kbd_led_use[2],
		kbd_led_status[1], kbd_led_use[1],
		kbd_led_status[0], kbd_led_use[0]};

	always_comb begin
		reply.valid = (frame.cmd_stb || frame.data_stb) &&
			(frame.cmd == hps_cmd_pkg::CMD_KBD || frame.cmd == hps_cmd_pkg::CMD_LEDS);
		reply.data  = (frame.data_stb && frame.cmd == hps_cmd_pkg::CMD_LEDS) ?
			led_word : '0;
	end

endmodule

//--- design/io_reply.sv
/*
 * Read reply stage of the bridge.
 * Registers the reply of whichever decoder owns the current strobe onto
 * io_dout and holds it until the next owned strobe. The word returns to
 * zero once io_enable drops between frames.
 */

`timescale 1ns/1ps

module io_reply (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  enable,
	input  hps_bus_pkg::reply_t   stat_reply,
	input  hps_bus_pkg::reply_t   key_reply,
	output hps_bus_pkg::io_word_t io_dout
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_dout <= '0;
		end else if (!enable) begin
			io_dout <= '0;
		end else if (stat_reply.valid) begin
			io_dout <= stat_reply.data;
		end else if (key_reply.valid) begin
			io_dout <= key_reply.data;
		end
	end

	// decoders split the command space, so only one owner per strobe
	a_one_owner: assert property (@(posedge clk_sys) disable iff (reset)
		!(stat_reply.valid && key_reply.valid));

endmodule

//--- design/hps_io_lite.sv
/*
 * Host-to-core I/O bridge, command channel only.
 * The host frames each transaction with io_enable and paces words with
 * io_strobe; the first word of a frame is the command. Exposes config,
 * joysticks, the status word and keyboard events to the core, and
 * returns read replies on io_dout.
 */

`timescale 1ns/1ps

module hps_io_lite (
	input  logic                    clk_sys,
	input  logic                    reset,

	// host bus
	input  logic                    io_strobe,
	input  logic                    io_enable,
	input  hps_bus_pkg::io_word_t   io_din,
	output hps_bus_pkg::io_word_t   io_dout,

	// core status request
	input  logic                    status_set,
	input  hps_bus_pkg::status_t    status_in,
	input  hps_bus_pkg::io_word_t   status_menumask,

	input  logic [2:0]              kbd_led_status,
	input  logic [2:0]              kbd_led_use,

	// core-facing outputs
	output logic [1:0]              buttons,
	output logic                    forced_scandoubler,
	output logic                    direct_video,
	output hps_bus_pkg::joy_t       joystick_0,
	output hps_bus_pkg::joy_t       joystick_1,
	output hps_bus_pkg::status_t    status,
	output hps_bus_pkg::key_event_t ps2_key
);

	hps_bus_pkg::host_bus_t host_bus;
	hps_bus_pkg::frame_t    frame;
	hps_bus_pkg::reply_t    stat_reply;
	hps_bus_pkg::reply_t    key_reply;
	hps_bus_pkg::io_word_t  cfg_word;

	assign host_bus = '{strobe: io_strobe, enable: io_enable, din: io_din};

	// remaining cfg bits are handled outside the core
	assign buttons            = cfg_word[1:0];
	assign forced_scandoubler = cfg_word[4];
	assign direct_video       = cfg_word[10];

	cmd_frame u_frame (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (host_bus),
		.frame   (frame)
	);

	status_regs u_status (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.frame           (frame),
		.status_set      (status_set),
		.status_in       (status_in),
		.status_menumask (status_menumask),
		.cfg_word        (cfg_word),
		.joystick_0      (joystick_0),
		.joystick_1      (joystick_1),
		.status          (status),
		.reply           (stat_reply)
	);

	key_events u_keys (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.frame          (frame),
		.kbd_led_status (kbd_led_status),
		.kbd_led_use    (kbd_led_use),
		.ps2_key        (ps2_key),
		.reply          (key_reply)
	);

	io_reply u_reply (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.enable     (io_enable),
		.stat_reply (stat_reply),
		.key_reply  (key_reply),
		.io_dout    (io_dout)
	);

endmodule

//--- tb/hps_host_tasks.svh
/*
 * Host-side bus tasks for the bridge testbench.
 * Included inside the testbench module. Every drive happens on the
 * falling clock edge. A frame raises io_enable, strobes the command word
 * and then the queued data words, each followed by an idle cycle, and
 * closes with two cycles of io_enable low.
 */

// one 16-bit word from the fixed-seed generator
function automatic hps_bus_pkg::io_word_t rand_word();
	logic [31:0] r;
	r = $random(seed);
	return r[15:0];
endfunction

function automatic hps_bus_pkg::status_t rand_status();
	logic [31:0] hi;
	logic [31:0] lo;
	hi = $random(seed);
	lo = $random(seed);
	return {hi, lo};
endfunction

task automatic queue_random(input int n);
	repeat (n)
		data_q.push_back(rand_word());
endtask

// strobe held for one cycle, then a gap cycle
task automatic put_word(input hps_bus_pkg::io_word_t word);
	io_din    = word;
	io_strobe = 1'b1;
	@(negedge clk_sys);
	io_strobe = 1'b0;
	@(negedge clk_sys);
endtask

// command word, then everything waiting in data_q
task automatic send_frame(input hps_bus_pkg::io_word_t cmd);
	io_enable = 1'b1;
	@(negedge clk_sys);
	put_word(cmd);
	while (data_q.size() > 0)
		put_word(data_q.pop_front());
	io_enable = 1'b0;
	@(negedge clk_sys);
	@(negedge clk_sys);
endtask

// keyboard frame with the lowest n bytes of seq, oldest byte first
task automatic send_keys(input logic [31:0] seq, input int n);
	for (int i = n - 1; i >= 0; i--)
		data_q.push_back({8'h00, seq[i * 8 +: 8]});
	send_frame(hps_cmd_pkg::CMD_KBD);
endtask

// one rising edge of the core's status-set request
task automatic pulse_status_set(input hps_bus_pkg::status_t value);
	status_in  = value;
	status_set = 1'b1;
	@(negedge clk_sys);
	status_set = 1'b0;
	@(negedge clk_sys);
endtask

//--- tb/tb_hps_io.sv
/*
 * Testbench for the host I/O bridge command channel.
 * Host frames are driven on the falling edge. A reference model follows
 * the same bus on the rising edge, and assertions sampled on the falling
 * edge compare every DUT output with it.
 */

`timescale 1ns/1ps

module tb_hps_io;

	localparam int CLK_PERIOD = 100;
	// a frame of n words takes 2n+3 cycles, summed over the sequence below
	localparam int SEQ_CYCLES = 226;

	logic                    clk_sys = 1'b0;
	logic                    reset;
	logic                    io_strobe;
	logic                    io_enable;
	hps_bus_pkg::io_word_t   io_din;
	hps_bus_pkg::io_word_t   io_dout;
	logic                    status_set;
	hps_bus_pkg::status_t    status_in;
	hps_bus_pkg::io_word_t   status_menumask;
	logic [2:0]              kbd_led_status;
	logic [2:0]              kbd_led_use;
	logic [1:0]              buttons;
	logic                    forced_scandoubler;
	logic                    direct_video;
	hps_bus_pkg::joy_t       joystick_0;
	hps_bus_pkg::joy_t       joystick_1;
	hps_bus_pkg::status_t    status;
	hps_bus_pkg::key_event_t ps2_key;

	integer                  seed = 93129;
	hps_bus_pkg::io_word_t   data_q[$];

	// reference model state
	hps_bus_pkg::io_word_t   exp_dout;
	hps_bus_pkg::io_word_t   exp_cfg;
	hps_bus_pkg::joy_t       exp_joy0;
	hps_bus_pkg::joy_t       exp_joy1;
	hps_bus_pkg::status_t    exp_status;
	hps_bus_pkg::key_event_t exp_key;
	hps_bus_pkg::status_t    set_capture;
	hps_bus_pkg::io_word_t   m_cmd;
	int                      m_cnt;
	logic                    frame_open;
	logic                    set_d;
	logic [3:0]              set_count;
	logic [31:0]             kbd_raw;
	logic                    kbd_skip;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	hps_io_lite UUT (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.status_set         (status_set),
		.status_in          (status_in),
		.status_menumask    (status_menumask),
		.kbd_led_status     (kbd_led_status),
		.kbd_led_use        (kbd_led_use),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_key            (ps2_key)
	);

	`include "hps_host_tasks.svh"

	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("Mismatch at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
		abort_run();
	endtask

	// event from the last four scan bytes, newest byte lowest
	function automatic hps_bus_pkg::key_event_t key_from_bytes(input logic toggle,
		input logic [31:0] raw);
		logic       released;
		logic       ext;
		logic [9:0] low;
		released = raw[15:8] == hps_cmd_pkg::KEY_BREAK;
		ext      = released ? (raw[23:16] == hps_cmd_pkg::KEY_EXT) :
			(raw[15:8] == hps_cmd_pkg::KEY_EXT);
		low      = {~released, ext, raw[7:0]};
		if (raw == hps_cmd_pkg::PRNSCR_MAKE)
			low = hps_cmd_pkg::PRNSCR_EV_MAKE;
		else if (raw == hps_cmd_pkg::PRNSCR_BREAK)
			low = hps_cmd_pkg::PRNSCR_EV_BREAK;
		else if (raw == hps_cmd_pkg::PAUSE_MAKE)
			low = hps_cmd_pkg::PAUSE_EV;
		return {~toggle, low};
	endfunction

	////////////////////
	// reference model
	////////////////////

	always @(posedge clk_sys) begin
		if (reset) begin
			exp_dout    <= '0;
			exp_cfg     <= '0;
			exp_joy0    <= '0;
			exp_joy1    <= '0;
			exp_status  <= '0;
			exp_key     <= '0;
			m_cmd       <= '0;
			m_cnt       <= 0;
			frame_open  <= 1'b0;
			set_d       <= 1'b0;
			set_count   <= '0;
			kbd_raw     <= '0;
			kbd_skip    <= 1'b0;
		end else begin
			set_d      <= status_set;
			frame_open <= io_enable;
			if (status_set && !set_d) begin
				set_count   <= set_count + 4'd1;
				set_capture <= status_in;
			end
			if (!io_enable) begin
				exp_dout <= '0;
				m_cnt    <= 0;
				kbd_skip <= 1'b0;
				if (frame_open && m_cmd == hps_cmd_pkg::CMD_KBD && !kbd_skip)
					exp_key <= key_from_bytes(exp_key[10], kbd_raw);
			end else if (io_strobe) begin
				m_cnt    <= m_cnt + 1;
				exp_dout <= '0;
				if (m_cnt == 0) begin
					m_cmd   <= io_din;
					kbd_raw <= '0;
					if (io_din == hps_cmd_pkg::CMD_STATUS_SET)
						exp_dout <= {8'h00, hps_cmd_pkg::STATUS_SET_TAG, set_count};
				end else begin
					case (m_cmd)
						hps_cmd_pkg::CMD_CFG: exp_cfg <= io_din;
						hps_cmd_pkg::CMD_JOY0:
							if (m_cnt == 1)
								exp_joy0[15:0] <= io_din;
							else
								exp_joy0[31:16] <= io_din;
						hps_cmd_pkg::CMD_JOY1:
							if (m_cnt == 1)
								exp_joy1[15:0] <= io_din;
							else
								exp_joy1[31:16] <= io_din;
						hps_cmd_pkg::CMD_STATUS:
							if (m_cnt <= 4)
								exp_status[(m_cnt - 1) * 16 +: 16] <= io_din;
						hps_cmd_pkg::CMD_KBD:
							if (io_din[15:8] == hps_cmd_pkg::SKIP_PREFIX)
								kbd_skip <= 1'b1;
							else if (!kbd_skip)
								kbd_raw <= {kbd_raw[23:0], io_din[7:0]};
						hps_cmd_pkg::CMD_LEDS:
							exp_dout <= {8'h00, 2'b01,
								kbd_led_status[2], kbd_led_use[2],
								kbd_led_status[1], kbd_led_use[1],
								kbd_led_status[0], kbd_led_use[0]};
						hps_cmd_pkg::CMD_STATUS_SET:
							if (m_cnt <= 4)
								exp_dout <= set_capture[(m_cnt - 1) * 16 +: 16];
						hps_cmd_pkg::CMD_MENUMASK:
							if (m_cnt == 1)
								exp_dout <= status_menumask;
						default: ;
					endcase
				end
			end
		end
	end

	////////////////////
	// checks
	////////////////////

	a_dout: assert property (@(negedge clk_sys) disable iff (reset) io_dout == exp_dout)
		else report_mismatch("io_dout", 64'(exp_dout), 64'(io_dout));
	a_idle: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(io_enable) |=> io_dout == '0)
		else report_mismatch("io_dout", 64'd0, 64'(io_dout));
	a_buttons: assert property (@(negedge clk_sys) disable iff (reset) buttons == exp_cfg[1:0])
		else report_mismatch("buttons", 64'(exp_cfg[1:0]), 64'(buttons));
	a_scandbl: assert property (@(negedge clk_sys) disable iff (reset)
		forced_scandoubler == exp_cfg[4])
		else report_mismatch("forced_scandoubler", 64'(exp_cfg[4]), 64'(forced_scandoubler));
	a_direct: assert property (@(negedge clk_sys) disable iff (reset)
		direct_video == exp_cfg[10])
		else report_mismatch("direct_video", 64'(exp_cfg[10]), 64'(direct_video));
	a_joy0: assert property (@(negedge clk_sys) disable iff (reset) joystick_0 == exp_joy0)
		else report_mismatch("joystick_0", 64'(exp_joy0), 64'(joystick_0));
	a_joy1: assert property (@(negedge clk_sys) disable iff (reset) joystick_1 == exp_joy1)
		else report_mismatch("joystick_1", 64'(exp_joy1), 64'(joystick_1));
	a_status: assert property (@(negedge clk_sys) disable iff (reset) status == exp_status)
		else report_mismatch("status", exp_status, status);
	a_key: assert property (@(negedge clk_sys) disable iff (reset) ps2_key == exp_key)
		else report_mismatch("ps2_key", 64'(exp_key), 64'(ps2_key));

	initial begin
		#(2 * SEQ_CYCLES * CLK_PERIOD);
		$display("Timeout: the sequence did not finish within %0d cycles", 2 * SEQ_CYCLES);
		abort_run();
	end

	initial begin
		hps_bus_pkg::io_word_t word;
		reset           = 1'b1;
		io_strobe       = 1'b0;
		io_enable       = 1'b0;
		io_din          = '0;
		status_set      = 1'b0;
		status_in       = '0;
		status_menumask = '0;
		kbd_led_status  = '0;
		kbd_led_use     = '0;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		repeat (2) @(negedge clk_sys);

		// config, joysticks and status from the host
		queue_random(1);
		send_frame(hps_cmd_pkg::CMD_CFG);
		queue_random(2);
		send_frame(hps_cmd_pkg::CMD_JOY0);
		queue_random(2);
		send_frame(hps_cmd_pkg::CMD_JOY1);
		queue_random(4);
		send_frame(hps_cmd_pkg::CMD_STATUS);

		// status-set requests, the second read after the counter wraps
		repeat (5) pulse_status_set(rand_status());
		queue_random(4);
		send_frame(hps_cmd_pkg::CMD_STATUS_SET);
		repeat (14) pulse_status_set(rand_status());
		queue_random(4);
		send_frame(hps_cmd_pkg::CMD_STATUS_SET);
		status_menumask = rand_word();
		queue_random(1);
		send_frame(hps_cmd_pkg::CMD_MENUMASK);

		// keyboard events
		send_keys(32'h0000001C, 1);
		send_keys(32'h0000F01C, 2);
		send_keys(32'h0000E075, 2);
		send_keys(32'h00E0F075, 3);
		send_keys(hps_cmd_pkg::PRNSCR_MAKE, 4);
		send_keys(hps_cmd_pkg::PRNSCR_BREAK, 4);
		send_keys(hps_cmd_pkg::PAUSE_MAKE, 4);
		data_q.push_back(16'h0012);
		data_q.push_back(16'hFF00);
		data_q.push_back(16'h0034);
		send_frame(hps_cmd_pkg::CMD_KBD);

		// LED status reads
		repeat (2) begin
			word           = rand_word();
			kbd_led_status = word[2:0];
			kbd_led_use    = word[5:3];
			queue_random(2);
			send_frame(hps_cmd_pkg::CMD_LEDS);
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- list.f
+incdir+tb
design/hps_bus_pkg.sv
design/hps_cmd_pkg.sv
design/cmd_frame.sv
design/status_regs.sv
design/key_events.sv
design/io_reply.sv
design/hps_io_lite.sv
tb/tb_hps_io.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_hps_io

out=$(./obj_dir/Vtb_hps_io 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
